/* hdl/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// byte address seen by the processor
`define CACHE_ADDR_W 16

// direct mapped, one word per line
`define CACHE_LINES 16
`define CACHE_INDEX_W 4

// address bits above the index
`define CACHE_TAG_W 10

`define CACHE_DATA_W 32

// backing store depth in words
`define MEM_WORDS 16384

// cycles from a memory request to its ready pulse
`define MEM_LATENCY 4

`endif

/* hdl/cache_pkg.sv */
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

    // address layout: tag | index | byte offset
    localparam int INDEX_LSB = 2;
    localparam int TAG_LSB = INDEX_LSB + `CACHE_INDEX_W;

    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic                     write;
    } cpu_req_t;

    // addr is always word aligned here
    typedef struct packed {
        logic [`CACHE_ADDR_W-1:0] addr;
        logic [`CACHE_DATA_W-1:0] wdata;
        logic                     write;
    } mem_req_t;

    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [`CACHE_TAG_W-1:0]  tag;
        logic [`CACHE_DATA_W-1:0] data;
    } cache_line_t;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        WRITE_BACK,
        ALLOCATE
    } cache_state_e;

endpackage

`default_nettype wire

/* hdl/cache_array.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_array (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [`CACHE_INDEX_W-1:0]  rd_index,
    output cache_pkg::cache_line_t     rd_line,
    input  logic                       wr_en,
    input  logic [`CACHE_INDEX_W-1:0]  wr_index,
    input  cache_pkg::cache_line_t     wr_line
);

    import cache_pkg::*;

    cache_line_t lines [`CACHE_LINES];

    // reset clears only the status bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `CACHE_LINES; i++)
            begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end
        else if (wr_en)
        begin
            lines[wr_index] <= wr_line;
        end
    end

    // asynchronous read so the controller compares in the same cycle
    assign rd_line = lines[rd_index];

    // the controller must not update a line while reset clears the array
    wr_quiet_in_reset: assert property (@(posedge clk) rst |-> !wr_en)
        else $error("cache_array: line write while reset is high");

endmodule

`default_nettype wire

/* hdl/cache_controller.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_controller (
    input  logic                       clk,
    input  logic                       rst,

    input  cache_pkg::cpu_req_t        cpu_req,
    input  logic                       cpu_req_valid,
    output logic [`CACHE_DATA_W-1:0]   cpu_rdata,
    output logic                       cpu_req_ready,

    output cache_pkg::mem_req_t        mem_req,
    output logic                       mem_req_valid,
    input  logic [`CACHE_DATA_W-1:0]   mem_rdata,
    input  logic                       mem_req_ready,

    output logic [`CACHE_INDEX_W-1:0]  rd_index,
    input  cache_pkg::cache_line_t     rd_line,
    output logic                       wr_en,
    output logic [`CACHE_INDEX_W-1:0]  wr_index,
    output cache_pkg::cache_line_t     wr_line
);

    import cache_pkg::*;

    cache_state_e state;
    cache_state_e state_next;

    logic [`CACHE_INDEX_W-1:0] req_index;
    logic [`CACHE_TAG_W-1:0]   req_tag;
    logic                      hit;
    logic                      victim_dirty;
    logic [`CACHE_ADDR_W-1:0]  victim_addr;
    logic [`CACHE_ADDR_W-1:0]  fill_addr;

    // the processor holds its request until ready, so no copy is kept
    assign req_index = cpu_req.addr[TAG_LSB-1:INDEX_LSB];
    assign req_tag   = cpu_req.addr[`CACHE_ADDR_W-1:TAG_LSB];

    assign rd_index = req_index;
    assign wr_index = req_index;

    assign hit          = rd_line.valid && (rd_line.tag == req_tag);
    assign victim_dirty = rd_line.valid && rd_line.dirty;

    assign victim_addr = {rd_line.tag, req_index, 2'b00};
    assign fill_addr   = {req_tag, req_index, 2'b00};

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            // ready high means the held request was just answered
            IDLE:
                if (cpu_req_valid && !cpu_req_ready)
                    state_next = COMPARE;
            COMPARE:
            begin
                if (hit)
                    state_next = IDLE;
                else if (victim_dirty)
                    state_next = WRITE_BACK;
                else
                    state_next = ALLOCATE;
            end
            WRITE_BACK:
                if (mem_req_ready)
                    state_next = ALLOCATE;
            ALLOCATE:
                if (mem_req_ready)
                    state_next = COMPARE;
            default:
                state_next = IDLE;
        endcase
    end

    // response to the processor, one cycle after the hit
    always_ff @(posedge clk)
    begin
        if (rst)
            cpu_req_ready <= 1'b0;
        else
            cpu_req_ready <= (state == COMPARE) && hit;
    end

    always_ff @(posedge clk)
    begin
        if (state == COMPARE && hit)
            cpu_rdata <= rd_line.data;
    end

    // line updates: write hit merge or refill
    always_comb
    begin
        wr_en   = 1'b0;
        wr_line = rd_line;
        if (state == COMPARE && hit && cpu_req.write)
        begin
            wr_en         = 1'b1;
            wr_line.dirty = 1'b1;
            wr_line.data  = cpu_req.wdata;
        end
        else if (state == ALLOCATE && mem_req_ready)
        begin
            wr_en         = 1'b1;
            wr_line.valid = 1'b1;
            wr_line.dirty = 1'b0;
            wr_line.tag   = req_tag;
            wr_line.data  = mem_rdata;
        end
    end

    // valid drops for a cycle between write-back and refill
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_valid <= 1'b0;
        end
        else if (mem_req_valid)
        begin
            if (mem_req_ready)
                mem_req_valid <= 1'b0;
        end
        else if (state == WRITE_BACK || state == ALLOCATE)
        begin
            mem_req_valid <= 1'b1;
        end
    end

    // request fields only move while no access is outstanding
    always_ff @(posedge clk)
    begin
        if (!mem_req_valid)
        begin
            mem_req.addr  <= (state == WRITE_BACK) ? victim_addr : fill_addr;
            mem_req.wdata <= rd_line.data;
            mem_req.write <= (state == WRITE_BACK);
        end
    end

    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else $error("cache_controller: memory request dropped or changed before ready");

    cpu_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        cpu_req_ready |=> !cpu_req_ready)
        else $error("cache_controller: cpu_req_ready held longer than one cycle");

    no_mem_in_idle: assert property (@(posedge clk) disable iff (rst)
        state == IDLE |-> !mem_req_valid)
        else $error("cache_controller: memory request outstanding in IDLE");

endmodule

`default_nettype wire

/* hdl/main_memory.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module main_memory (
    input  logic                      clk,
    input  logic                      rst,
    input  cache_pkg::mem_req_t       mem_req,
    input  logic                      mem_req_valid,
    output logic [`CACHE_DATA_W-1:0]  mem_rdata,
    output logic                      mem_req_ready
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    logic [`CACHE_DATA_W-1:0] mem [`MEM_WORDS];

    logic [`CACHE_ADDR_W-3:0] word_idx;
    logic [CNT_W-1:0]         count;
    logic                     busy;
    logic                     valid_q;
    logic                     start;

    initial
    begin
        for (int i = 0; i < `MEM_WORDS; i++)
            mem[i] = '0;
    end

    assign word_idx = mem_req.addr[`CACHE_ADDR_W-1:2];

    // new access only on a rising valid
    assign start = mem_req_valid && !valid_q && !busy;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy    <= 1'b0;
            count   <= '0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= mem_req_valid;
            if (start)
            begin
                busy  <= 1'b1;
                count <= CNT_W'(1);
            end
            else if (mem_req_ready)
            begin
                busy  <= 1'b0;
                count <= '0;
            end
            else if (busy)
            begin
                count <= count + 1'b1;
            end
        end
    end

    assign mem_req_ready = busy && (count == CNT_W'(`MEM_LATENCY));

    // read data is valid alongside ready
    assign mem_rdata = mem[word_idx];

    always_ff @(posedge clk)
    begin
        if (mem_req_ready && mem_req.write)
            mem[word_idx] <= mem_req.wdata;
    end

    addr_in_range: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid |-> (mem_req.addr[1:0] == 2'b00) && (int'(word_idx) < `MEM_WORDS))
        else $error("main_memory: request address %h out of range", mem_req.addr);

endmodule

`default_nettype wire

/* hdl/cache_subsystem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_subsystem (
    input  logic                      clk,
    input  logic                      rst,
    input  cache_pkg::cpu_req_t       cpu_req,
    input  logic                      cpu_req_valid,
    output logic [`CACHE_DATA_W-1:0]  cpu_rdata,
    output logic                      cpu_req_ready
);

    import cache_pkg::*;

    mem_req_t                  mem_req;
    logic                      mem_req_valid;
    logic [`CACHE_DATA_W-1:0]  mem_rdata;
    logic                      mem_req_ready;

    logic [`CACHE_INDEX_W-1:0] rd_index;
    cache_line_t               rd_line;
    logic                      wr_en;
    logic [`CACHE_INDEX_W-1:0] wr_index;
    cache_line_t               wr_line;

    cache_controller u_controller (
        .clk           (clk),
        .rst           (rst),
        .cpu_req       (cpu_req),
        .cpu_req_valid (cpu_req_valid),
        .cpu_rdata     (cpu_rdata),
        .cpu_req_ready (cpu_req_ready),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_rdata     (mem_rdata),
        .mem_req_ready (mem_req_ready),
        .rd_index      (rd_index),
        .rd_line       (rd_line),
        .wr_en         (wr_en),
        .wr_index      (wr_index),
        .wr_line       (wr_line)
    );

    cache_array u_array (
        .clk      (clk),
        .rst      (rst),
        .rd_index (rd_index),
        .rd_line  (rd_line),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_line  (wr_line)
    );

    main_memory u_memory (
        .clk           (clk),
        .rst           (rst),
        .mem_req       (mem_req),
        .mem_req_valid (mem_req_valid),
        .mem_rdata     (mem_rdata),
        .mem_req_ready (mem_req_ready)
    );

endmodule

`default_nettype wire

/* bench/cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "cache_config.svh"

module cache_tb;

    import cache_pkg::*;

    localparam int NUM_REQS = 600;
    localparam int RESET_CYCLES = 5;
    // valid seen at the next edge, COMPARE answers one edge later,
    // ready is sampled at the edge after that
    localparam int HIT_CYCLES = 3;
    localparam int TIMEOUT_CYCLES =
        NUM_REQS * (2 * `MEM_LATENCY + 12) + RESET_CYCLES + 10;

    logic                     clk = 1'b0;
    logic                     rst;
    cpu_req_t                 cpu_req;
    logic                     cpu_req_valid;
    logic [`CACHE_DATA_W-1:0] cpu_rdata;
    logic                     cpu_req_ready;

    // reference models
    logic [`CACHE_DATA_W-1:0] model_mem [`MEM_WORDS];
    logic                     written [`MEM_WORDS];
    logic                     tag_valid [`CACHE_LINES];
    logic [`CACHE_TAG_W-1:0]  tag_model [`CACHE_LINES];
    logic [`CACHE_TAG_W-1:0]  tag_pool [3];

    logic [31:0]               rng_state;
    int                        cycle_count = 0;
    int                        latency;
    int                        gap;
    int                        num_hits = 0;
    int                        num_misses = 0;
    logic [15:0]               r;
    logic [`CACHE_ADDR_W-3:0]  word;
    logic [`CACHE_INDEX_W-1:0] index;
    logic [`CACHE_TAG_W-1:0]   tag;
    logic                      predict_hit;
    cpu_req_t                  req;

    cache_subsystem DUT (
        .clk           (clk),
        .rst           (rst),
        .cpu_req       (cpu_req),
        .cpu_req_valid (cpu_req_valid),
        .cpu_rdata     (cpu_rdata),
        .cpu_req_ready (cpu_req_ready)
    );

    always #10 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("ERROR: timeout, the cache stopped answering after %0d cycles",
                     cycle_count);
            $display("TEST FAILED");
            $fatal(1, "simulation timeout");
        end
    end

    // upper half of the LCG state since the low bits cycle too quickly
    function automatic logic [15:0] rand16();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("FAILED %s: expected 0x%08h actual 0x%08h", name, expected, actual);
        $display("TEST FAILED");
        $fatal(1, "check %s failed", name);
    endtask

    task automatic stop_with_error(input string what);
        $display("ERROR: %s", what);
        $display("TEST FAILED");
        $fatal(1, "%s", what);
    endtask

    initial
    begin
        rng_state = 32'd27461;
        rst = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req = '0;
        req = '0;
        tag_pool[0] = 10'h000;
        tag_pool[1] = 10'h2a5;
        tag_pool[2] = 10'h3ff;
        for (int i = 0; i < `MEM_WORDS; i++)
        begin
            model_mem[i] = '0;
            written[i] = 1'b0;
        end
        for (int i = 0; i < `CACHE_LINES; i++)
        begin
            tag_valid[i] = 1'b0;
            tag_model[i] = '0;
        end

        // first edge only loads the reset values
        @(posedge clk);
        for (int i = 1; i < RESET_CYCLES; i++)
        begin
            @(posedge clk);
            assert (cpu_req_ready === 1'b0)
                else report_mismatch("reset_idle", 32'd0, 32'(cpu_req_ready));
        end
        rst <= 1'b0;
        repeat (2)
        begin
            @(posedge clk);
            assert (cpu_req_ready === 1'b0)
                else report_mismatch("reset_idle", 32'd0, 32'(cpu_req_ready));
        end

        for (int n = 0; n < NUM_REQS; n++)
        begin
            // 3 tags over all 16 indexes gives hits and conflicts
            r = rand16();
            index = r[3:0];
            r = rand16();
            tag = tag_pool[r % 16'd3];
            r = rand16();
            req.write = r[15];
            req.addr = {tag, index, 2'b00};
            req.wdata = {rand16(), rand16()};
            predict_hit = tag_valid[index] && (tag_model[index] == tag);

            cpu_req <= req;
            cpu_req_valid <= 1'b1;

            @(posedge clk);
            latency = 1;
            assert (cpu_req_ready === 1'b0)
                else stop_with_error("ready_pulse: ready high in the first cycle of a request");
            while (cpu_req_ready !== 1'b1)
            begin
                @(posedge clk);
                latency++;
            end

            if (predict_hit)
            begin
                assert (latency == HIT_CYCLES)
                    else report_mismatch("hit_latency", 32'(HIT_CYCLES), 32'(latency));
                num_hits++;
            end
            else
            begin
                assert (latency >= HIT_CYCLES + `MEM_LATENCY)
                    else report_mismatch("miss_latency", 32'(HIT_CYCLES + `MEM_LATENCY),
                                         32'(latency));
                num_misses++;
            end
            // write-allocate so the line always ends up holding this tag
            tag_valid[index] = 1'b1;
            tag_model[index] = tag;

            word = req.addr[`CACHE_ADDR_W-1:2];
            if (req.write)
            begin
                model_mem[word] = req.wdata;
                written[word] = 1'b1;
            end
            else if (written[word])
            begin
                assert (cpu_rdata === model_mem[word])
                    else report_mismatch("write_then_read", model_mem[word], cpu_rdata);
            end
            else
            begin
                assert (cpu_rdata === model_mem[word])
                    else report_mismatch("read_data", model_mem[word], cpu_rdata);
            end

            gap = int'(rand16() % 16'd4);
            if (gap > 0)
            begin
                cpu_req_valid <= 1'b0;
                repeat (gap)
                begin
                    @(posedge clk);
                    assert (cpu_req_ready === 1'b0)
                        else stop_with_error("ready_pulse: ready without a pending request");
                end
            end
        end

        cpu_req_valid <= 1'b0;
        repeat (3)
        begin
            @(posedge clk);
            assert (cpu_req_ready === 1'b0)
                else stop_with_error("ready_pulse: ready after the last request was answered");
        end

        $display("%0d requests, %0d hits, %0d misses", NUM_REQS, num_hits, num_misses);
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hdl
hdl/cache_pkg.sv
hdl/cache_array.sv
hdl/cache_controller.sv
hdl/main_memory.sv
hdl/cache_subsystem.sv
bench/cache_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cache_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# pass only if the run printed the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
